// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

SOURCES := $(wildcard source/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// right-shifting galois form, taps 32 30 26 25
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
endfunction

function automatic exu_pkg::xlen_t sext32(input exu_pkg::word_t v);
  return {{32{v[31]}}, v};
endfunction

function automatic exu_pkg::xlen_t alu_result_of(input exu_pkg::alu_op_t op, input logic word,
                                                 input exu_pkg::xlen_t a,
                                                 input exu_pkg::xlen_t b);
  exu_pkg::xlen_t r;
  exu_pkg::xlen_t lo;
  logic [5:0]     sh;
  // word shifts use five amount bits on the low half
  sh = word ? {1'b0, b[4:0]} : b[5:0];
  lo = word ? {32'b0, a[31:0]} : a;
  case (op)
    exu_pkg::ALU_ADD:   r = a + b;
    exu_pkg::ALU_SUB:   r = a - b;
    exu_pkg::ALU_SLL:   r = lo << sh;
    exu_pkg::ALU_SRL:   r = lo >> sh;
    exu_pkg::ALU_SRA:   r = word ? $signed(sext32(a[31:0])) >>> sh : $signed(a) >>> sh;
    exu_pkg::ALU_SLT:   r = {63'b0, $signed(a) < $signed(b)};
    exu_pkg::ALU_SLTU:  r = {63'b0, a < b};
    exu_pkg::ALU_XOR:   r = a ^ b;
    exu_pkg::ALU_OR:    r = a | b;
    exu_pkg::ALU_AND:   r = a & b;
    exu_pkg::ALU_PASS2: r = b;
    default:            r = '0;
  endcase
  return word ? sext32(r[31:0]) : r;
endfunction

function automatic logic cmp_less(input exu_pkg::alu_op_t op, input exu_pkg::xlen_t a,
                                  input exu_pkg::xlen_t b);
  if (op == exu_pkg::ALU_SLTU) begin
    return a < b;
  end
  return $signed(a) < $signed(b);
endfunction

// adder output is a difference only for the subtracting ops
function automatic logic sum_is_zero(input exu_pkg::alu_op_t op, input exu_pkg::xlen_t a,
                                     input exu_pkg::xlen_t b);
  if ((op == exu_pkg::ALU_SUB) || (op == exu_pkg::ALU_SLT) || (op == exu_pkg::ALU_SLTU)) begin
    return (a - b) == '0;
  end
  return (a + b) == '0;
endfunction

function automatic exu_pkg::xlen_t product_word(input exu_pkg::md_op_t op, input logic word,
                                                input exu_pkg::xlen_t a,
                                                input exu_pkg::xlen_t b);
  logic [127:0]   x;
  logic [127:0]   y;
  logic [127:0]   p;
  exu_pkg::word_t lo;
  lo = a[31:0] * b[31:0];
  x  = {64'b0, a};
  y  = {64'b0, b};
  if ((op == exu_pkg::MD_MULH) || (op == exu_pkg::MD_MULHSU)) begin
    x = {{64{a[63]}}, a};
  end
  if (op == exu_pkg::MD_MULH) begin
    y = {{64{b[63]}}, b};
  end
  p = x * y;
  if (word) begin
    return sext32(lo);
  end
  return (op == exu_pkg::MD_MUL) ? p[63:0] : p[127:64];
endfunction

// risc-v rules for a zero divisor and for the most negative value over -1
function automatic exu_pkg::xlen_t quotient_or_rem(input exu_pkg::md_op_t op, input logic word,
                                                   input exu_pkg::xlen_t a,
                                                   input exu_pkg::xlen_t b);
  exu_pkg::xlen_t x;
  exu_pkg::xlen_t y;
  exu_pkg::xlen_t q;
  exu_pkg::xlen_t r;
  logic           sgn;
  sgn = (op == exu_pkg::MD_DIV) || (op == exu_pkg::MD_REM);
  x   = a;
  y   = b;
  if (word) begin
    x = sgn ? sext32(a[31:0]) : {32'b0, a[31:0]};
    y = sgn ? sext32(b[31:0]) : {32'b0, b[31:0]};
  end
  if (y == '0) begin
    q = '1;
    r = x;
  end else if (sgn && (x == {1'b1, 63'b0}) && (y == '1)) begin
    q = x;
    r = '0;
  end else if (sgn) begin
    q = $signed(x) / $signed(y);
    r = $signed(x) % $signed(y);
  end else begin
    q = x / y;
    r = x % y;
  end
  if ((op == exu_pkg::MD_REM) || (op == exu_pkg::MD_REMU)) begin
    q = r;
  end
  // signed word overflow lands on 0x80000000 in the low half
  return word ? sext32(q[31:0]) : q;
endfunction

`endif

// File: bench/tb_exec_unit.sv
module tb_exec_unit;

  `include "tb_ref_model.svh"

  localparam int N_RAND     = 16;
  localparam int N_MD_RAND  = 4;
  localparam int ALU_OPS    = 2 * 11 * (25 + 20 + N_RAND) + 5;
  localparam int MD_OPS     = 13 * (15 + N_MD_RAND) + 4;
  // a multiply/divide occupies 67 cycles from issue to release
  localparam int MAX_CYCLES = ALU_OPS + MD_OPS * 70 + 200;

  logic             clk;
  logic             rst_n;
  exu_pkg::alu_op_t alu_op;
  logic             word;
  exu_pkg::xlen_t   src1;
  exu_pkg::xlen_t   src2;
  logic             md_en;
  exu_pkg::md_op_t  md_op;
  logic             flush;
  exu_pkg::xlen_t   result;
  logic             less;
  logic             zero;
  logic             stall;

  logic             chk_alu;
  logic             chk_md;
  exu_pkg::xlen_t   exp_res;
  logic             exp_less;
  logic             exp_zero;
  int               stall_run = 0;
  int               cycle_cnt = 0;
  int               err_cnt   = 0;
  int               op_cnt    = 0;
  int               test_cnt  = 0;
  logic [31:0]      lfsr_q    = 32'd89;

  exu_pkg::alu_op_t alu_ops [11] = '{exu_pkg::ALU_ADD, exu_pkg::ALU_SUB, exu_pkg::ALU_SLL,
                                     exu_pkg::ALU_SLT, exu_pkg::ALU_SLTU, exu_pkg::ALU_XOR,
                                     exu_pkg::ALU_SRL, exu_pkg::ALU_SRA, exu_pkg::ALU_OR,
                                     exu_pkg::ALU_AND, exu_pkg::ALU_PASS2};
  exu_pkg::xlen_t   corners [5]  = '{64'd0, 64'd1, '1, 64'h8000_0000_0000_0000,
                                     64'hFFFF_FFFF_8000_0000};
  exu_pkg::xlen_t   shamts [4]   = '{64'd0, 64'd31, 64'd32, 64'd63};

  exec_unit UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .alu_op_i (alu_op),
    .word_i   (word),
    .src1_i   (src1),
    .src2_i   (src2),
    .md_en_i  (md_en),
    .md_op_i  (md_op),
    .flush_i  (flush),
    .result_o (result),
    .less_o   (less),
    .zero_o   (zero),
    .stall_o  (stall)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // consecutive stall cycles of the operation in flight
  always @(posedge clk) begin
    if (!chk_md || !stall) begin
      stall_run <= 0;
    end else begin
      stall_run <= stall_run + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run stopped, still busy after %0d cycles", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  a_alu_result: assert property (@(posedge clk) chk_alu |-> (result == exp_res))
    else begin
      err_cnt++;
      $display("FAIL result_o expected %h actual %h", $sampled(exp_res), $sampled(result));
    end
  a_alu_less: assert property (@(posedge clk) chk_alu |-> (less == exp_less))
    else begin
      err_cnt++;
      $display("FAIL less_o expected %h actual %h", $sampled(exp_less), $sampled(less));
    end
  a_alu_zero: assert property (@(posedge clk) chk_alu |-> (zero == exp_zero))
    else begin
      err_cnt++;
      $display("FAIL zero_o expected %h actual %h", $sampled(exp_zero), $sampled(zero));
    end
  a_alu_stall: assert property (@(posedge clk) (chk_alu || !rst_n) |-> !stall)
    else begin
      err_cnt++;
      $display("FAIL stall_o expected 0 actual %h", $sampled(stall));
    end
  a_md_result: assert property (@(posedge clk) (chk_md && !stall) |-> (result == exp_res))
    else begin
      err_cnt++;
      $display("FAIL result_o expected %h actual %h", $sampled(exp_res), $sampled(result));
    end
  a_md_length: assert property (@(posedge clk) (chk_md && !stall) |-> (stall_run == 66))
    else begin
      err_cnt++;
      $display("FAIL stall_o cycles expected %h actual %h", 66, $sampled(stall_run));
    end
  a_md_overrun: assert property (@(posedge clk) (chk_md && stall) |-> (stall_run < 66))
    else begin
      err_cnt++;
      $display("stall_o still high after 66 cycles");
    end
  a_flush: assert property (@(posedge clk) disable iff (!rst_n) $past(flush) |-> !stall)
    else begin
      err_cnt++;
      $display("stall_o did not drop in the cycle after flush_i");
    end

  task automatic random_bits(input int n, output exu_pkg::xlen_t v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
  endtask

  task automatic drive_alu(input exu_pkg::alu_op_t op, input logic w,
                           input exu_pkg::xlen_t a, input exu_pkg::xlen_t b);
    alu_op   = op;
    word     = w;
    src1     = a;
    src2     = b;
    md_en    = 1'b0;
    chk_md   = 1'b0;
    exp_res  = alu_result_of(op, w, a, b);
    exp_less = cmp_less(op, a, b);
    exp_zero = sum_is_zero(op, a, b);
    chk_alu  = 1'b1;
    op_cnt++;
    @(posedge clk);
    #1;
  endtask

  // hold keeps md_en high so the same operation issues again
  task automatic run_md(input exu_pkg::md_op_t op, input logic w, input exu_pkg::xlen_t a,
                        input exu_pkg::xlen_t b, input logic hold);
    int n;
    md_op   = op;
    word    = w;
    src1    = a;
    src2    = b;
    md_en   = 1'b1;
    chk_alu = 1'b0;
    chk_md  = 1'b1;
    exp_res = op[2] ? quotient_or_rem(op, w, a, b) : product_word(op, w, a, b);
    op_cnt++;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (stall && (n < 80));
    if (stall) begin
      err_cnt++;
      $display("stall_o still high %0d cycles after issue", n);
    end
    // done cycle, checked on its closing edge
    @(posedge clk);
    #1;
    if (!hold) begin
      md_en  = 1'b0;
      chk_md = 1'b0;
    end
  endtask

  task automatic alu_set(input logic w);
    exu_pkg::xlen_t a;
    exu_pkg::xlen_t b;
    foreach (alu_ops[k]) begin
      foreach (corners[i]) begin
        foreach (corners[j]) begin
          drive_alu(alu_ops[k], w, corners[i], corners[j]);
        end
        foreach (shamts[j]) begin
          drive_alu(alu_ops[k], w, corners[i], shamts[j]);
        end
      end
      repeat (N_RAND) begin
        random_bits(64, a);
        random_bits(64, b);
        drive_alu(alu_ops[k], w, a, b);
      end
    end
  endtask

  task automatic md_set(input exu_pkg::md_op_t op, input logic w);
    exu_pkg::xlen_t a;
    exu_pkg::xlen_t b;
    exu_pkg::xlen_t sh;
    foreach (corners[i]) begin
      run_md(op, w, corners[i], 64'd0, 1'b0);
      run_md(op, w, corners[i], corners[1], 1'b0);
      run_md(op, w, corners[i], corners[2], 1'b0);
    end
    repeat (N_MD_RAND) begin
      random_bits(64, a);
      random_bits(64, b);
      random_bits(6, sh);
      // narrower divisors give longer quotients
      run_md(op, w, a, b >> sh, 1'b0);
    end
  endtask

  task automatic report_test(input string name, input int err_start, input int op_start);
    test_cnt++;
    $display("test %-10s %5d ops, %0d errors", name, op_cnt - op_start, err_cnt - err_start);
  endtask

  initial begin
    int             e0;
    int             o0;
    exu_pkg::xlen_t a;
    exu_pkg::xlen_t b;
    rst_n   = 1'b0;
    alu_op  = exu_pkg::ALU_ADD;
    word    = 1'b0;
    src1    = '0;
    src2    = '0;
    md_en   = 1'b0;
    md_op   = exu_pkg::MD_MUL;
    flush   = 1'b0;
    chk_alu = 1'b0;
    chk_md  = 1'b0;
    exp_res = '0;

    // two cycles in reset, then the first cycle out of it
    e0 = err_cnt;
    o0 = op_cnt;
    drive_alu(exu_pkg::ALU_ADD, 1'b0, corners[3], corners[2]);
    drive_alu(exu_pkg::ALU_SUB, 1'b1, corners[4], corners[1]);
    rst_n = 1'b1;
    drive_alu(exu_pkg::ALU_SLTU, 1'b0, corners[1], corners[2]);
    report_test("reset", e0, o0);

    e0 = err_cnt;
    o0 = op_cnt;
    alu_set(1'b0);
    report_test("alu64", e0, o0);
    e0 = err_cnt;
    o0 = op_cnt;
    alu_set(1'b1);
    report_test("alu_word", e0, o0);

    e0 = err_cnt;
    o0 = op_cnt;
    for (int m = 0; m < 4; m++) begin
      md_set(exu_pkg::md_op_t'(m), 1'b0);
    end
    md_set(exu_pkg::MD_MUL, 1'b1);
    report_test("mul", e0, o0);

    e0 = err_cnt;
    o0 = op_cnt;
    for (int m = 4; m < 8; m++) begin
      md_set(exu_pkg::md_op_t'(m), 1'b0);
      md_set(exu_pkg::md_op_t'(m), 1'b1);
    end
    report_test("div", e0, o0);

    e0 = err_cnt;
    o0 = op_cnt;
    random_bits(64, a);
    random_bits(64, b);
    run_md(exu_pkg::MD_MULHU, 1'b0, a, b, 1'b1);
    run_md(exu_pkg::MD_MULHU, 1'b0, a, b, 1'b0);
    report_test("back2back", e0, o0);

    // divide cut short by a one-cycle flush
    e0 = err_cnt;
    o0 = op_cnt;
    md_op = exu_pkg::MD_DIV;
    word  = 1'b0;
    src1  = a;
    src2  = b;
    md_en = 1'b1;
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    drive_alu(exu_pkg::ALU_XOR, 1'b0, a, b);
    drive_alu(exu_pkg::ALU_ADD, 1'b1, a, b);
    run_md(exu_pkg::MD_REM, 1'b1, a, b >> 40, 1'b0);
    report_test("flush", e0, o0);

    chk_alu = 1'b0;
    $display("%0d tests, %0d operations, %0d errors", test_cnt, op_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+bench
source/exu_pkg.sv
source/alu_shifter.sv
source/alu_core.sv
source/mul_iter.sv
source/div_iter.sv
source/exec_unit.sv
bench/tb_exec_unit.sv

// File: source/alu_core.sv
module alu_core (
  input  exu_pkg::alu_op_t op_i,
  input  logic             word_i,
  input  exu_pkg::xlen_t   src1_i,
  input  exu_pkg::xlen_t   src2_i,
  output exu_pkg::xlen_t   result_o,
  output logic             less_o,
  output logic             zero_o
);

  localparam int MSB = exu_pkg::XLEN - 1;

  logic           sub;
  exu_pkg::xlen_t src2_inv;
  exu_pkg::xlen_t add_out;
  exu_pkg::xlen_t diff;
  logic           carry;
  logic           overflow;
  exu_pkg::xlen_t sum;
  logic           less_s;
  logic           less_u;
  logic           right;
  logic           arith;
  exu_pkg::xlen_t shift;

  assign sub = (op_i == exu_pkg::ALU_SUB) ||
               (op_i == exu_pkg::ALU_SLT) ||
               (op_i == exu_pkg::ALU_SLTU);

  assign add_out = src1_i + src2_i;

  // subtract through inverted src2 and carry-in
  assign src2_inv      = ~src2_i;
  assign {carry, diff} = {1'b0, src1_i} + {1'b0, src2_inv} + {{MSB{1'b0}}, 2'b01};

  assign sum    = sub ? diff : add_out;
  assign zero_o = (sum == '0);

  // compare flags always come from the difference
  assign overflow = (src1_i[MSB] == src2_inv[MSB]) && (diff[MSB] != src1_i[MSB]);
  assign less_s   = diff[MSB] ^ overflow;
  // no carry out means a borrow
  assign less_u   = ~carry;
  assign less_o   = (op_i == exu_pkg::ALU_SLTU) ? less_u : less_s;

  assign right = (op_i == exu_pkg::ALU_SRL) || (op_i == exu_pkg::ALU_SRA);
  assign arith = (op_i == exu_pkg::ALU_SRA);

  alu_shifter u_shifter (
    .src_i   (src1_i),
    .shamt_i (src2_i[5:0]),
    .right_i (right),
    .arith_i (arith),
    .word_i  (word_i),
    .shift_o (shift)
  );

  always_comb begin
    case (op_i)
      exu_pkg::ALU_ADD,
      exu_pkg::ALU_SUB: begin
        result_o = sum;
      end
      exu_pkg::ALU_SLL,
      exu_pkg::ALU_SRL,
      exu_pkg::ALU_SRA: begin
        result_o = shift;
      end
      exu_pkg::ALU_SLT,
      exu_pkg::ALU_SLTU: begin
        result_o = {{MSB{1'b0}}, less_o};
      end
      exu_pkg::ALU_PASS2: begin
        result_o = src2_i;
      end
      exu_pkg::ALU_XOR: begin
        result_o = src1_i ^ src2_i;
      end
      exu_pkg::ALU_OR: begin
        result_o = src1_i | src2_i;
      end
      exu_pkg::ALU_AND: begin
        result_o = src1_i & src2_i;
      end
      default: begin
        result_o = sum;
      end
    endcase
  end

endmodule

// File: source/alu_shifter.sv
module alu_shifter (
  input  exu_pkg::xlen_t  src_i,
  input  exu_pkg::shamt_t shamt_i,
  input  logic            right_i,
  input  logic            arith_i,
  input  logic            word_i,
  output exu_pkg::xlen_t  shift_o
);

  localparam int XW = exu_pkg::XLEN;

  exu_pkg::xlen_t  base;
  exu_pkg::xlen_t  base_rev;
  exu_pkg::shamt_t amt;
  exu_pkg::xlen_t  pre;
  exu_pkg::xlen_t  srl_out;
  exu_pkg::xlen_t  srl_rev;
  exu_pkg::word_t  word_mask;
  exu_pkg::xlen_t  fill_mask;
  logic            sign_bit;

  // word ops only see the low half and a 5-bit amount
  assign base = word_i ? {{(XW-32){1'b0}}, src_i[31:0]} : src_i;
  assign amt  = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;

  // left shifts reverse the bits, shift right and reverse back
  assign base_rev = {<<{base}};
  assign pre      = right_i ? base : base_rev;
  assign srl_out  = pre >> amt;
  assign srl_rev  = {<<{srl_out}};

  // vacated bits for arithmetic right shifts
  assign sign_bit  = word_i ? src_i[31] : src_i[XW-1];
  assign word_mask = ~(32'hFFFF_FFFF >> amt[4:0]);
  assign fill_mask = word_i ? {{(XW-32){1'b1}}, word_mask} : ~({XW{1'b1}} >> amt);

  always_comb begin
    if (!right_i) begin
      shift_o = srl_rev;
    end else if (arith_i && sign_bit) begin
      shift_o = srl_out | fill_mask;
    end else begin
      shift_o = srl_out;
    end
  end

endmodule

// File: source/div_iter.sv
module div_iter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            flush_i,
  input  exu_pkg::md_op_t op_i,
  input  logic            word_i,
  input  exu_pkg::xlen_t  a_i,
  input  exu_pkg::xlen_t  b_i,
  output logic            done_o,
  output logic            busy_o,
  output exu_pkg::xlen_t  result_o
);

  localparam int         XW       = exu_pkg::XLEN;
  localparam logic [6:0] LAST_CNT = 7'(XW);

  exu_pkg::md_state_t state_q;
  logic [6:0]         cnt_q;
  exu_pkg::md_op_t    op_q;
  logic               q_neg_q;
  logic               r_neg_q;
  logic               zero_q;
  logic               ovf_q;
  exu_pkg::xlen_t     dvd_q;
  exu_pkg::xlen_t     dvs_q;
  exu_pkg::xlen_t     quo_q;
  exu_pkg::xlen_t     rem_q;
  exu_pkg::xlen_t     result_q;

  logic               sgn;
  logic               a_neg;
  logic               b_neg;
  exu_pkg::xlen_t     a_mag;
  exu_pkg::xlen_t     b_mag;
  exu_pkg::xlen_t     min_val;
  logic [XW:0]        shifted;
  logic [XW+1:0]      trial;
  exu_pkg::xlen_t     q_fix;
  exu_pkg::xlen_t     r_fix;
  exu_pkg::xlen_t     q_out;
  exu_pkg::xlen_t     r_out;

  // only DIV and REM are signed
  assign sgn   = ~op_i[0];
  assign a_neg = sgn & a_i[XW-1];
  assign b_neg = sgn & b_i[XW-1];
  assign a_mag = a_neg ? -a_i : a_i;
  assign b_mag = b_neg ? -b_i : b_i;

  // operands arrive already extended, so the word minimum is sign-extended too
  assign min_val = word_i ? {{(XW-31){1'b1}}, 31'b0} : {1'b1, {(XW-1){1'b0}}};

  // restoring step brings in the next dividend bit and tries the subtract
  assign shifted = {rem_q, quo_q[XW-1]};
  assign trial   = {1'b0, shifted} - {2'b00, dvs_q};

  assign q_fix = q_neg_q ? -quo_q : quo_q;
  assign r_fix = r_neg_q ? -rem_q : rem_q;

  always_comb begin
    q_out = q_fix;
    r_out = r_fix;
    if (zero_q) begin
      q_out = '1;
      r_out = dvd_q;
    end else if (ovf_q) begin
      q_out = dvd_q;
      r_out = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        exu_pkg::MD_IDLE: begin
          if (start_i) begin
            state_q <= exu_pkg::MD_BUSY;
          end
          cnt_q <= '0;
        end
        exu_pkg::MD_BUSY: begin
          if (cnt_q == LAST_CNT) begin
            state_q <= exu_pkg::MD_DONE;
          end
          cnt_q <= cnt_q + 7'd1;
        end
        default: begin
          state_q <= exu_pkg::MD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == exu_pkg::MD_IDLE) && start_i) begin
      op_q    <= op_i;
      q_neg_q <= a_neg ^ b_neg;
      r_neg_q <= a_neg;
      zero_q  <= (b_i == '0);
      ovf_q   <= sgn && (b_i == '1) && (a_i == min_val);
      dvd_q   <= a_i;
      dvs_q   <= b_mag;
      quo_q   <= a_mag;
      rem_q   <= '0;
    end else if (state_q == exu_pkg::MD_BUSY) begin
      if (cnt_q == LAST_CNT) begin
        // REM and REMU have bit 1 set
        result_q <= op_q[1] ? r_out : q_out;
      end else begin
        rem_q <= trial[XW+1] ? shifted[XW-1:0] : trial[XW-1:0];
        quo_q <= {quo_q[XW-2:0], ~trial[XW+1]};
      end
    end
  end

  assign busy_o   = (state_q == exu_pkg::MD_BUSY);
  assign done_o   = (state_q == exu_pkg::MD_DONE);
  assign result_o = result_q;

  // top level must hold off new starts until the unit is back in idle
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (state_q == exu_pkg::MD_IDLE));

endmodule

// File: source/exec_unit.sv
module exec_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  exu_pkg::alu_op_t alu_op_i,
  input  logic             word_i,
  input  exu_pkg::xlen_t   src1_i,
  input  exu_pkg::xlen_t   src2_i,
  input  logic             md_en_i,
  input  exu_pkg::md_op_t  md_op_i,
  input  logic             flush_i,
  output exu_pkg::xlen_t   result_o,
  output logic             less_o,
  output logic             zero_o,
  output logic             stall_o
);

  localparam int HI = exu_pkg::XLEN - 32;

  exu_pkg::xlen_t alu_result;
  logic           is_div;
  logic           div_signed;
  logic           mul_start;
  logic           mul_busy;
  logic           mul_done;
  exu_pkg::xlen_t mul_result;
  logic           div_start;
  logic           div_busy;
  logic           div_done;
  exu_pkg::xlen_t div_result;
  exu_pkg::xlen_t div_a;
  exu_pkg::xlen_t div_b;
  logic           md_done;
  exu_pkg::xlen_t md_result;
  exu_pkg::xlen_t raw_result;
  exu_pkg::word_t raw_lo;

  alu_core u_alu (
    .op_i     (alu_op_i),
    .word_i   (word_i),
    .src1_i   (src1_i),
    .src2_i   (src2_i),
    .result_o (alu_result),
    .less_o   (less_o),
    .zero_o   (zero_o)
  );

  assign is_div     = md_op_i[2];
  assign div_signed = ~md_op_i[0];

  // start only from idle, so a held md_en_i restarts after done
  assign mul_start = md_en_i && !is_div && !mul_busy && !mul_done && !flush_i;
  assign div_start = md_en_i && is_div && !div_busy && !div_done && !flush_i;

  // W divides see sign- or zero-extended low halves
  assign div_a = !word_i    ? src1_i :
                 div_signed ? {{HI{src1_i[31]}}, src1_i[31:0]} : {{HI{1'b0}}, src1_i[31:0]};
  assign div_b = !word_i    ? src2_i :
                 div_signed ? {{HI{src2_i[31]}}, src2_i[31:0]} : {{HI{1'b0}}, src2_i[31:0]};

  mul_iter u_mul (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start),
    .flush_i  (flush_i),
    .op_i     (md_op_i),
    .word_i   (word_i),
    .a_i      (src1_i),
    .b_i      (src2_i),
    .done_o   (mul_done),
    .busy_o   (mul_busy),
    .result_o (mul_result)
  );

  div_iter u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (div_start),
    .flush_i  (flush_i),
    .op_i     (md_op_i),
    .word_i   (word_i),
    .a_i      (div_a),
    .b_i      (div_b),
    .done_o   (div_done),
    .busy_o   (div_busy),
    .result_o (div_result)
  );

  assign md_done   = is_div ? div_done : mul_done;
  assign md_result = is_div ? div_result : mul_result;

  assign raw_result = md_en_i ? md_result : alu_result;
  assign raw_lo     = raw_result[31:0];
  assign result_o   = word_i ? {{HI{raw_lo[31]}}, raw_lo} : raw_result;

  // hold issue until the selected unit reports done
  assign stall_o = md_en_i && !md_done;

endmodule

// File: source/exu_pkg.sv
package exu_pkg;

  // integer datapath width
  localparam int XLEN = 64;

  // one register operand or result
  typedef logic [XLEN-1:0] xlen_t;

  // low half seen by the W forms
  typedef logic [31:0] word_t;

  // shift amount, bit 5 only for 64-bit shifts
  typedef logic [5:0] shamt_t;

  // alu opcodes
  // low three bits pick the result path, bit 3 picks the variant
  typedef enum logic [3:0] {
    ALU_ADD   = 4'b0000,
    ALU_SUB   = 4'b1000,
    ALU_SLL   = 4'b0001,
    ALU_SLT   = 4'b0010,
    ALU_SLTU  = 4'b1010,
    ALU_PASS2 = 4'b0011,
    ALU_XOR   = 4'b0100,
    ALU_SRL   = 4'b0101,
    ALU_SRA   = 4'b1101,
    ALU_OR    = 4'b0110,
    ALU_AND   = 4'b0111
  } alu_op_t;

  // multiply/divide opcodes, funct3 order
  // top bit set means the divider
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_t;

  // shared by the multiplier and divider
  typedef enum logic [1:0] {
    MD_IDLE = 2'd0,
    MD_BUSY = 2'd1,
    MD_DONE = 2'd2
  } md_state_t;

endpackage

// File: source/mul_iter.sv
module mul_iter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            flush_i,
  input  exu_pkg::md_op_t op_i,
  input  logic            word_i,
  input  exu_pkg::xlen_t  a_i,
  input  exu_pkg::xlen_t  b_i,
  output logic            done_o,
  output logic            busy_o,
  output exu_pkg::xlen_t  result_o
);

  localparam int         XW       = exu_pkg::XLEN;
  localparam logic [6:0] LAST_CNT = 7'(XW);

  exu_pkg::md_state_t state_q;
  logic [6:0]         cnt_q;
  exu_pkg::md_op_t    op_q;
  logic               neg_q;
  exu_pkg::xlen_t     mcand_q;
  logic [2*XW-1:0]    prod_q;
  exu_pkg::xlen_t     result_q;

  exu_pkg::xlen_t     a_ext;
  exu_pkg::xlen_t     b_ext;
  logic               a_neg;
  logic               b_neg;
  exu_pkg::xlen_t     a_mag;
  exu_pkg::xlen_t     b_mag;
  logic [XW:0]        part_sum;
  logic [2*XW-1:0]    prod_fix;

  // MULW: low 32 bits of the sign-extended halves
  assign a_ext = word_i ? {{(XW-32){a_i[31]}}, a_i[31:0]} : a_i;
  assign b_ext = word_i ? {{(XW-32){b_i[31]}}, b_i[31:0]} : b_i;

  // MUL keeps unsigned magnitudes, the low word is the same
  assign a_neg = ((op_i == exu_pkg::MD_MULH) || (op_i == exu_pkg::MD_MULHSU)) && a_ext[XW-1];
  assign b_neg = (op_i == exu_pkg::MD_MULH) && b_ext[XW-1];
  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;

  // one multiplier bit per cycle from the low end of prod_q
  assign part_sum = {1'b0, prod_q[2*XW-1:XW]} + (prod_q[0] ? {1'b0, mcand_q} : '0);
  assign prod_fix = neg_q ? -prod_q : prod_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        exu_pkg::MD_IDLE: begin
          if (start_i) begin
            state_q <= exu_pkg::MD_BUSY;
          end
          cnt_q <= '0;
        end
        exu_pkg::MD_BUSY: begin
          // count LAST_CNT is the sign fix-up cycle
          if (cnt_q == LAST_CNT) begin
            state_q <= exu_pkg::MD_DONE;
          end
          cnt_q <= cnt_q + 7'd1;
        end
        default: begin
          state_q <= exu_pkg::MD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == exu_pkg::MD_IDLE) && start_i) begin
      op_q    <= op_i;
      neg_q   <= a_neg ^ b_neg;
      mcand_q <= a_mag;
      prod_q  <= {{XW{1'b0}}, b_mag};
    end else if (state_q == exu_pkg::MD_BUSY) begin
      if (cnt_q == LAST_CNT) begin
        result_q <= (op_q == exu_pkg::MD_MUL) ? prod_fix[XW-1:0] : prod_fix[2*XW-1:XW];
      end else begin
        prod_q <= {part_sum, prod_q[XW-1:1]};
      end
    end
  end

  assign busy_o   = (state_q == exu_pkg::MD_BUSY);
  assign done_o   = (state_q == exu_pkg::MD_DONE);
  assign result_o = result_q;

  // top level must hold off new starts until the unit is back in idle
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (state_q == exu_pkg::MD_IDLE));

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |=> !done_o);

endmodule
